//--- verilog/osf_pkg.sv
`default_nettype none

package osf_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int n_chan	= 4;						// filter channels
	localparam int w_data	= 18;						// adc word width
	localparam int w_osm	= 4;						// oversample mode width
	localparam int w_dly	= 16;						// settling delay width, also host value width
	localparam int w_sum	= w_data + (2**w_osm - 1);	// room for 2^15 samples
	localparam int w_chan	= $clog2(n_chan);			// channel index width

	//////////////////////////////////////////////////
	// enums
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		st_idle		= 2'd0,		// waiting for activation
		st_delay	= 2'd1,		// settling, samples thrown away
		st_sample	= 2'd2,		// accumulating a window
		st_send		= 2'd3		// average on the output for one cycle
	} osf_state_t;

	typedef enum logic [2:0] {
		op_nop			= 3'd0,
		op_set_osm		= 3'd1,	// staging osm
		op_set_delay	= 3'd2,	// staging cycle delay
		op_activate		= 3'd3,
		op_deactivate	= 3'd4,
		op_commit		= 3'd5	// value[3:0] is the channel mask
	} cfg_op_t;

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////

	typedef struct packed {
		cfg_op_t			op;
		logic [w_chan-1:0]	chan;
		logic [w_dly-1:0]	value;
	} cfg_cmd_t;

	typedef struct packed {
		logic [w_osm-1:0]	osm;			// log2 of the window length
		logic [w_dly-1:0]	cycle_delay;	// samples skipped between windows
		logic				active;
	} chan_cfg_t;

	typedef struct packed {
		logic signed [w_data-1:0]	data;
		logic						valid;
	} adc_sample_t;

	typedef struct packed {
		logic [w_chan-1:0]			chan;
		logic signed [w_data-1:0]	data;
	} osf_result_t;

endpackage

`default_nettype wire

//--- verilog/channel_config.sv
`timescale 1ns/1ps
`default_nettype none

module channel_config (
	input  wire					clk_in,
	input  wire					osf_reset,
	input  wire osf_pkg::cfg_cmd_t	cmd,						// one cycle per command
	output osf_pkg::chan_cfg_t		cfg [osf_pkg::n_chan]		// live parameters
);
	import osf_pkg::*;

	logic [w_osm-1:0]	stg_osm [n_chan];		// staging osm per channel
	logic [w_dly-1:0]	stg_dly [n_chan];		// staging delay per channel

	//////////////////////////////////////////////////
	// staging registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			for (int k = 0; k < n_chan; k++) begin
				stg_osm[k] <= '0;
				stg_dly[k] <= '0;
			end
		end else begin
			case (cmd.op)
				op_set_osm:		stg_osm[cmd.chan] <= cmd.value[w_osm-1:0];	// upper bits ignored
				op_set_delay:	stg_dly[cmd.chan] <= cmd.value;
				default: ;														// other ops leave staging alone
			endcase
		end
	end

	//////////////////////////////////////////////////
	// live registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			for (int k = 0; k < n_chan; k++) begin
				cfg[k] <= '0;					// inactive, osm 0, delay 0
			end
		end else begin
			case (cmd.op)
				op_activate:	cfg[cmd.chan].active <= 1'b1;	// takes effect right away
				op_deactivate:	cfg[cmd.chan].active <= 1'b0;
				op_commit: begin
					for (int k = 0; k < n_chan; k++) begin
						if (cmd.value[k]) begin			// masked channels only
							cfg[k].osm			<= stg_osm[k];
							cfg[k].cycle_delay	<= stg_dly[k];
						end
					end
				end
				default: ;								// nop and staging writes
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/oversample_filter.sv
`timescale 1ns/1ps
`default_nettype none

module oversample_filter (
	input  wire								clk_in,
	input  wire								osf_reset,
	input  wire osf_pkg::chan_cfg_t			cfg,		// live channel parameters
	input  wire osf_pkg::adc_sample_t		adc,		// broadcast adc word
	output logic							res_valid,	// one cycle per window
	output logic signed [osf_pkg::w_data-1:0]	res_data
);
	import osf_pkg::*;

	logic						clr;		// system reset or channel off
	osf_state_t					state;
	osf_state_t					state_nxt;
	logic [w_dly-1:0]			cnt;		// valid samples seen in this state
	logic [w_dly-1:0]			cnt_inc;
	logic [w_osm-1:0]			osm_cur;	// osm frozen for the running window
	logic signed [w_sum-1:0]	sum;
	logic						take;		// sample goes into the sum

	//////////////////////////////////////////////////
	// combinational
	//////////////////////////////////////////////////

	assign clr		= osf_reset | ~cfg.active;
	assign cnt_inc	= cnt + 1'b1;
	assign take		= (state == st_sample) & adc.valid;

	assign res_valid	= (state == st_send);
	assign res_data		= w_data'(sum >>> osm_cur);	// floor divide, always in range

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (cfg.active) begin
					state_nxt = st_sample;			// no settling on the first window
				end
			end
			st_delay: begin
				if (cfg.cycle_delay == '0) begin
					state_nxt = st_sample;
				end else if (adc.valid && (cnt_inc == cfg.cycle_delay)) begin
					state_nxt = st_sample;			// last skipped sample
				end
			end
			st_sample: begin
				if (take && cnt_inc[osm_cur]) begin
					state_nxt = st_send;			// 2^osm samples in
				end
			end
			st_send: begin
				state_nxt = st_delay;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// state, counter, window osm
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (clr) begin
			state	<= st_idle;
			cnt		<= '0;
			osm_cur	<= '0;
		end else begin
			state <= state_nxt;
			if (state_nxt != state) begin
				cnt <= '0;						// restart on every state change
			end else if (adc.valid) begin
				cnt <= cnt_inc;
			end
			if ((state == st_idle) || (state == st_delay)) begin
				osm_cur <= cfg.osm;				// picked up before the window opens
			end
		end
	end

	// accumulator
	always_ff @(posedge clk_in) begin
		if (clr || (state == st_idle) || (state == st_delay)) begin
			sum <= '0;
		end else if (take) begin
			sum <= sum + w_sum'(adc.data);		// sign extended
		end
	end

endmodule

`default_nettype wire

//--- verilog/result_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module result_arbiter (
	input  wire									clk_in,
	input  wire									osf_reset,
	input  wire [osf_pkg::n_chan-1:0]			res_valid,
	input  wire signed [osf_pkg::w_data-1:0]	res_data [osf_pkg::n_chan],
	output osf_pkg::osf_result_t				out_result,
	output logic								out_req,
	input  wire									out_ack,
	output logic [osf_pkg::n_chan-1:0]			overflow		// sticky per channel
);
	import osf_pkg::*;

	typedef enum logic [1:0] {
		hs_idle		= 2'd0,		// nothing on the port
		hs_req		= 2'd1,		// req high, waiting for ack
		hs_release	= 2'd2		// req low, waiting for ack to drop
	} hs_state_t;

	hs_state_t					hs_state;
	logic [n_chan-1:0]			full;			// holding register occupied
	logic signed [w_data-1:0]	hold [n_chan];
	logic [w_chan-1:0]			last;			// channel served last
	logic [w_chan-1:0]			sel;
	logic [w_chan-1:0]			idx;
	logic						any_full;
	logic						grant;			// result moves to the port
	logic [n_chan-1:0]			freed;
	logic [n_chan-1:0]			accept;
	logic [n_chan-1:0]			drop;

	//////////////////////////////////////////////////
	// round robin pick
	//////////////////////////////////////////////////

	always_comb begin
		sel			= last;
		idx			= last;
		any_full	= 1'b0;
		for (int i = 1; i <= n_chan; i++) begin
			idx = w_chan'(last + i);			// wraps past the top channel
			if (!any_full && full[idx]) begin
				sel			= idx;
				any_full	= 1'b1;
			end
		end
	end

	assign grant = (hs_state == hs_idle) & any_full;

	always_comb begin
		for (int k = 0; k < n_chan; k++) begin
			freed[k] = grant && (sel == k);
		end
	end

	assign accept	= res_valid & (~full | freed);		// a slot emptied this edge is reusable
	assign drop		= res_valid & full & ~freed;

	//////////////////////////////////////////////////
	// holding registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			full		<= '0;
			overflow	<= '0;
		end else begin
			full		<= (full & ~freed) | accept;
			overflow	<= overflow | drop;			// cleared only by reset
		end
	end

	always_ff @(posedge clk_in) begin
		for (int k = 0; k < n_chan; k++) begin
			if (accept[k]) begin
				hold[k] <= res_data[k];
			end
		end
	end

	//////////////////////////////////////////////////
	// four phase handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			hs_state	<= hs_idle;
			last		<= w_chan'(n_chan - 1);		// channel 0 goes first
		end else begin
			case (hs_state)
				hs_idle: begin
					if (any_full) begin
						hs_state	<= hs_req;
						last		<= sel;
					end
				end
				hs_req: begin
					if (out_ack) begin
						hs_state <= hs_release;		// req drops
					end
				end
				hs_release: begin
					if (!out_ack) begin
						hs_state <= hs_idle;		// sink done, next result allowed
					end
				end
				default: begin
					hs_state <= hs_idle;
				end
			endcase
		end
	end

	// loaded one edge ahead of req so the port is stable
	always_ff @(posedge clk_in) begin
		if (grant) begin
			out_result.chan	<= sel;
			out_result.data	<= hold[sel];
		end
	end

	assign out_req = (hs_state == hs_req);

endmodule

`default_nettype wire

//--- verilog/osf_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module osf_bank_top (
	input  wire							clk_in,
	input  wire							osf_reset,
	input  wire osf_pkg::cfg_cmd_t		cmd,			// host command port
	input  wire osf_pkg::adc_sample_t	adc,			// shared by all channels
	output osf_pkg::osf_result_t		out_result,
	output logic						out_req,
	input  wire							out_ack,
	output logic [osf_pkg::n_chan-1:0]	overflow
);
	import osf_pkg::*;

	chan_cfg_t					cfg [n_chan];		// live parameters per channel
	wire [n_chan-1:0]			res_valid;
	wire signed [w_data-1:0]	res_data [n_chan];

	//////////////////////////////////////////////////
	// host config
	//////////////////////////////////////////////////

	channel_config i_channel_config (
		.clk_in		(clk_in),
		.osf_reset	(osf_reset),
		.cmd		(cmd),
		.cfg		(cfg)
	);

	//////////////////////////////////////////////////
	// filter channels
	//////////////////////////////////////////////////

	for (genvar k = 0; k < n_chan; k++) begin : g_filt
		oversample_filter i_oversample_filter (
			.clk_in		(clk_in),
			.osf_reset	(osf_reset),
			.cfg		(cfg[k]),
			.adc		(adc),
			.res_valid	(res_valid[k]),
			.res_data	(res_data[k])
		);
	end

	//////////////////////////////////////////////////
	// output drain
	//////////////////////////////////////////////////

	result_arbiter i_result_arbiter (
		.clk_in		(clk_in),
		.osf_reset	(osf_reset),
		.res_valid	(res_valid),
		.res_data	(res_data),
		.out_result	(out_result),
		.out_req	(out_req),
		.out_ack	(out_ack),
		.overflow	(overflow)
	);

endmodule

`default_nettype wire

//--- sim/osf_bank_props.sv
`timescale 1ns/1ps
`default_nettype none

module osf_bank_props (
	input  wire							clk_in,
	input  wire							osf_reset,
	input  wire osf_pkg::osf_result_t	out_result,
	input  wire							out_req,
	input  wire							out_ack,
	input  wire [osf_pkg::n_chan-1:0]	res_valid
);
	import osf_pkg::*;

	int fails = 0;		// failed assertions seen by the testbench

	// port data held for the whole request
	a_result_stable: assert property (@(posedge clk_in) disable iff (osf_reset)
		out_req |=> (!out_req || $stable(out_result)))
		else begin
			fails++;
			$error("out_result moved under req");
		end

	a_req_waits_ack: assert property (@(posedge clk_in) disable iff (osf_reset)
		(out_req && !out_ack) |=> out_req)
		else begin
			fails++;
			$error("req dropped before ack");
		end

	a_req_after_release: assert property (@(posedge clk_in) disable iff (osf_reset)
		$rose(out_req) |-> !out_ack)
		else begin
			fails++;
			$error("req rose with ack still high");
		end

	// one cycle st_send per window
	a_valid_pulse: assert property (@(posedge clk_in) disable iff (osf_reset)
		(|res_valid) |=> ((res_valid & $past(res_valid)) == '0))
		else begin
			fails++;
			$error("res_valid held");
		end

endmodule

bind osf_bank_top osf_bank_props i_osf_bank_props (
	.clk_in		(clk_in),
	.osf_reset	(osf_reset),
	.out_result	(out_result),
	.out_req	(out_req),
	.out_ack	(out_ack),
	.res_valid	(res_valid)
);

`default_nettype wire

//--- sim/osf_bank_tb.sv
`timescale 1ns/1ps
`default_nettype none

module osf_bank_tb;
	import osf_pkg::*;

	logic				clk_in;
	logic				osf_reset;
	cfg_cmd_t			cmd;
	adc_sample_t		adc;
	osf_result_t		out_result;
	logic				out_req;
	logic				out_ack;
	logic [n_chan-1:0]	overflow;

	int				errors;
	int				n_rec;				// records in the stimulus file
	int				seed = 29;
	bit				ack_hold;			// sink stalls while set
	int				exp_q [n_chan][$];	// expected averages per channel
	int				order_q [$];		// expected channel order, when given

	osf_bank_top i_osf_bank_top (
		.clk_in		(clk_in),
		.osf_reset	(osf_reset),
		.cmd		(cmd),
		.adc		(adc),
		.out_result	(out_result),
		.out_req	(out_req),
		.out_ack	(out_ack),
		.overflow	(overflow)
	);

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;		// 40 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic check(input string what, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic send_cmd(input int op, input int chan, input int value);
		cmd.op		<= cfg_op_t'(op);
		cmd.chan	<= chan[w_chan-1:0];
		cmd.value	<= value[w_dly-1:0];
		@(posedge clk_in);
		cmd.op <= op_nop;
		@(posedge clk_in);						// new cfg settles into the filters
	endtask

	task automatic send_sample(input int value);
		adc.data	<= value[w_data-1:0];
		adc.valid	<= 1'b1;
		@(posedge clk_in);
		adc.valid <= 1'b0;
		repeat (3) @(posedge clk_in);			// four cycles per sample
	endtask

	task automatic take_result();
		int ch;
		int got;
		ch	= out_result.chan;
		got	= $signed(out_result.data);
		if (order_q.size() != 0) begin
			check("result channel", ch, order_q.pop_front());
		end
		if (exp_q[ch].size() == 0) begin
			errors++;
			$display("result %0d on channel %0d arrived with no expected value left", got, ch);
		end else begin
			check("average", got, exp_q[ch].pop_front());
		end
	endtask

	//////////////////////////////////////////////////
	// sink side of the output handshake
	//////////////////////////////////////////////////

	initial begin
		int d;
		forever begin
			@(negedge clk_in);
			if (out_req) begin
				take_result();
				@(posedge clk_in);
				while (ack_hold) @(posedge clk_in);		// long back-pressure
				d = 1 + ({$random(seed)} % 3);
				repeat (d - 1) @(posedge clk_in);
				out_ack <= 1'b1;
				do @(negedge clk_in); while (out_req);
				@(posedge clk_in);
				out_ack <= 1'b0;
			end
		end
	end

	// watchdog sized from the record count
	initial begin
		#1;
		repeat (n_rec * 40 + 100) @(posedge clk_in);
		$display("timeout: the run did not finish in the allowed time");
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// stimulus file
	//////////////////////////////////////////////////

	initial begin
		int fd;
		int n;
		int a;
		int b;
		int c;
		int rc;
		int a_fails;
		logic [7:0] tag;
		reg [8*160-1:0] line;
		errors		= 0;
		ack_hold	= 1'b0;
		osf_reset	= 1'b1;
		cmd			= '0;				// op_nop
		adc			= '0;
		out_ack		= 1'b0;
		n_rec		= 0;
		fd = $fopen("sim/osf_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			$display("Checks failed");
			$finish;
		end else begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				n_rec++;
				rc = $fgets(line, fd);
			end
			$fclose(fd);
			fd = $fopen("sim/osf_stimulus.txt", "r");
			repeat (16) @(posedge clk_in);
			osf_reset <= 1'b0;
			@(negedge clk_in);
			check("out_req after reset", out_req, 0);
			check("overflow after reset", overflow, 0);
			@(posedge clk_in);
			while ($fscanf(fd, " %c", tag) == 1) begin
				case (tag)
					"#": rc = $fgets(line, fd);			// comment line
					"C": begin
						rc = $fscanf(fd, "%d %d %d", a, b, c);
						send_cmd(a, b, c);
					end
					"S": begin
						rc = $fscanf(fd, "%d", n);
						for (int i = 0; i < n; i++) begin
							rc = $fscanf(fd, "%d", a);
							send_sample(a);
						end
					end
					"E": begin
						rc = $fscanf(fd, "%d %d", a, b);
						exp_q[a].push_back(b);
					end
					"K": begin
						rc = $fscanf(fd, "%d", n);
						for (int i = 0; i < n; i++) begin
							rc = $fscanf(fd, "%d", a);
							order_q.push_back(a);
						end
					end
					"D": begin
						rc = $fscanf(fd, "%d", n);
						repeat (n) @(posedge clk_in);
					end
					"H": begin
						rc = $fscanf(fd, "%d", n);
						ack_hold <= (n != 0);
					end
					"O": begin
						rc = $fscanf(fd, "%d", a);
						@(negedge clk_in);
						check("overflow flags", overflow, a);
						@(posedge clk_in);
					end
					default: begin
						errors++;
						$display("unknown record type in the stimulus file");
						rc = $fgets(line, fd);
					end
				endcase
			end
			$fclose(fd);
			repeat (20) @(posedge clk_in);			// let the port drain
			for (int k = 0; k < n_chan; k++) begin
				if (exp_q[k].size() != 0) begin
					errors++;
					$display("channel %0d: %0d expected results never arrived", k, exp_q[k].size());
				end
			end
			if (order_q.size() != 0) begin
				errors++;
				$display("%0d results of the expected channel order never arrived", order_q.size());
			end
			a_fails = i_osf_bank_top.i_osf_bank_props.fails;
			$display("errors: %0d, assertion failures: %0d", errors, a_fails);
			if ((errors == 0) && (a_fails == 0)) begin
				$display("All checks passed");
			end else begin
				$display("Checks failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/osf_stimulus.txt
# C op chan value | S count samples | E chan average | K count chan order
# D idle cycles | H ack hold 1/0 | O expected overflow mask
C 3 3 0
E 3 5
E 3 -7
S 1 5
D 10
S 1 -7
D 10
C 4 3 0
C 1 0 2
C 5 0 1
C 3 0 0
E 0 25
E 0 -9
S 8 10 20 30 41 -10 -20 -3 0
D 12
C 4 0 0
C 2 0 3
C 5 0 1
C 3 0 0
E 0 2
E 0 -2
E 0 8
S 18 1 2 3 4 100 100 100 -1 -1 -1 -2 7 7 7 8 8 8 8
D 12
C 4 0 0
C 1 1 1
C 1 2 1
C 5 0 6
C 1 1 2
C 1 2 3
C 5 0 2
C 3 1 0
C 3 2 0
E 1 10
E 1 2
E 2 6
E 2 14
E 2 1
E 2 4
S 4 4 8 12 16
D 20
S 4 1 2 3 5
D 20
C 4 2 0
S 2 50 60
C 4 1 0
S 1 999
C 3 1 0
E 1 6
S 4 3 5 7 9
D 20
C 4 1 0
C 1 0 1
C 2 0 0
C 1 3 4
C 5 0 15
K 5 0 1 2 3 0
H 1
C 3 0 0
C 3 1 0
C 3 2 0
C 3 3 0
E 0 1
E 0 3
E 1 2
E 2 4
E 3 8
S 16 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16
D 8
O 7
H 0
D 60

//--- project.f
verilog/osf_pkg.sv
verilog/channel_config.sv
verilog/oversample_filter.sv
verilog/result_arbiter.sv
verilog/osf_bank_top.sv
sim/osf_bank_props.sv
sim/osf_bank_tb.sv
